//--- src/scc_pkg.sv
package scc_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int NUM_CH     = 3;
    localparam int WAVE_DEPTH = 32;
    localparam int WAVE_AW    = 5;
    localparam int FREQ_W     = 12;
    localparam int VOL_W      = 4;
    localparam int SAMPLE_W   = 8;
    localparam int MIX_W      = 10;
    localparam int MUL_STEPS  = 8;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    // Top three address bits of every register
    localparam logic [2:0] REG_REGION = 3'b100;

    // Voice n: low byte at base+2n, high nibble at base+2n+1
    localparam logic [7:0] FREQ_BASE = 8'h80;
    localparam logic [7:0] VOL_BASE  = 8'h8A;
    localparam logic [7:0] MUTE_ADDR = 8'h8F;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic signed [SAMPLE_W-1:0] wave_sample_t;
    typedef logic [FREQ_W-1:0] freq_t;
    typedef logic [VOL_W-1:0] vol_t;

    typedef struct packed {
        logic [2:0]         voice;
        logic [WAVE_AW-1:0] index;
    } wave_addr_t;

    typedef struct packed {
        logic [2:0] region;
        logic       unused;
        logic [3:0] regnum;
    } reg_addr_t;

    // Same CPU address seen as a wave RAM access or a register access
    typedef union packed {
        wave_addr_t wave;
        reg_addr_t  regs;
    } scc_addr_u;

endpackage

//--- src/scc_regs.sv
`timescale 1ns/1ps

module scc_regs
    import scc_pkg::*;
(
    input  logic               emuclk,
    input  logic               rst_n,
    input  logic               i_cs_n,
    input  logic               i_wr_n,
    input  logic               i_rd_n,
    input  logic [7:0]         i_addr,
    input  logic [7:0]         i_data,
    input  wave_sample_t       i_ram_rdata [NUM_CH],
    output logic [7:0]         o_data,
    output logic [NUM_CH-1:0]  o_ram_we,
    output logic [WAVE_AW-1:0] o_ram_waddr,
    output wave_sample_t       o_ram_wdata,
    output freq_t              o_freq [NUM_CH],
    output vol_t               o_vol [NUM_CH],
    output logic [NUM_CH-1:0]  o_enable,
    output logic [NUM_CH-1:0]  o_freq_load
);

    scc_addr_u         addr;
    logic              wr_en;
    logic              rd_en;
    logic              reg_wr;
    logic [NUM_CH-1:0] freq_lo_wr;
    logic [NUM_CH-1:0] freq_hi_wr;
    logic [NUM_CH-1:0] vol_wr;
    logic              mute_wr;

    assign addr   = i_addr;
    assign wr_en  = ~i_cs_n & ~i_wr_n;
    assign rd_en  = ~i_cs_n & ~i_rd_n;
    assign reg_wr = wr_en & (addr.regs.region == REG_REGION);

    //////////////////////////////////////////////////
    // Access decode
    //////////////////////////////////////////////////

    always_comb begin
        for (int n = 0; n < NUM_CH; n++) begin
            o_ram_we[n]   = wr_en & (addr.wave.voice == 3'(n));
            freq_lo_wr[n] = reg_wr & (addr.regs.regnum == FREQ_BASE[3:0] + 4'(2 * n));
            freq_hi_wr[n] = reg_wr & (addr.regs.regnum == FREQ_BASE[3:0] + 4'(2 * n + 1));
            vol_wr[n]     = reg_wr & (addr.regs.regnum == VOL_BASE[3:0] + 4'(n));
        end
    end

    assign mute_wr     = reg_wr & (addr.regs.regnum == MUTE_ADDR[3:0]);
    assign o_ram_waddr = addr.wave.index;
    assign o_ram_wdata = i_data;

    // Read-back only for wave RAM of voices 0 to 2
    always_comb begin
        o_data = '0;
        for (int n = 0; n < NUM_CH; n++) begin
            if (rd_en && addr.wave.voice == 3'(n)) begin
                o_data = i_ram_rdata[n];
            end
        end
    end

    //////////////////////////////////////////////////
    // Frequency, volume and mute registers
    //////////////////////////////////////////////////

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < NUM_CH; n++) begin
                o_freq[n] <= '0;
                o_vol[n]  <= '0;
            end
            o_enable    <= '0;
            o_freq_load <= '0;
        end else begin
            for (int n = 0; n < NUM_CH; n++) begin
                if (freq_lo_wr[n]) begin
                    o_freq[n][7:0] <= i_data;
                end
                if (freq_hi_wr[n]) begin
                    o_freq[n][FREQ_W-1:8] <= i_data[3:0];
                end
                if (vol_wr[n]) begin
                    o_vol[n] <= i_data[VOL_W-1:0];
                end
            end
            // Pulse lines up with the new value
            o_freq_load <= freq_lo_wr | freq_hi_wr;
            if (mute_wr) begin
                o_enable <= i_data[NUM_CH-1:0];
            end
        end
    end

endmodule

//--- src/scc_wave_ram.sv
`timescale 1ns/1ps

module scc_wave_ram
    import scc_pkg::*;
(
    input  logic               emuclk,
    input  logic               rst_n,
    input  logic               i_we,
    input  logic [WAVE_AW-1:0] i_waddr,
    input  wave_sample_t       i_wdata,
    input  logic [WAVE_AW-1:0] i_play_addr,
    output wave_sample_t       o_play_data,
    output wave_sample_t       o_cpu_data
);

    wave_sample_t mem [WAVE_DEPTH];

    //////////////////////////////////////////////////
    // CPU write port
    //////////////////////////////////////////////////

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < WAVE_DEPTH; n++) begin
                mem[n] <= '0;
            end
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Both read ports are asynchronous
    assign o_play_data = mem[i_play_addr];

    // CPU read shares the write address
    assign o_cpu_data = mem[i_waddr];

endmodule

//--- src/scc_voice.sv
`timescale 1ns/1ps

module scc_voice
    import scc_pkg::*;
(
    input  logic               emuclk,
    input  logic               rst_n,
    input  freq_t              i_freq,
    input  logic               i_freq_load,
    input  vol_t               i_vol,
    input  logic               i_enable,
    input  wave_sample_t       i_wave,
    output logic [WAVE_AW-1:0] o_play_addr,
    output wave_sample_t       o_sample
);

    freq_t                            cnt;
    logic                             tick;
    vol_t                             vol_lat;
    logic                             wave_pend;
    logic                             busy;
    logic [2:0]                       step;
    logic                             last_step;
    logic [SAMPLE_W-1:0]              wave_sh;
    logic signed [SAMPLE_W+VOL_W-1:0] addend;
    logic signed [SAMPLE_W+VOL_W-1:0] acc;
    logic signed [SAMPLE_W+VOL_W-1:0] acc_next;

    //////////////////////////////////////////////////
    // Period counter and sample index
    //////////////////////////////////////////////////

    // Counter runs freq down to 0, so freq+1 cycles per tick
    assign tick = (cnt == '0) && !i_freq_load;

    assign last_step = (step == 3'(MUL_STEPS - 1));

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            o_play_addr <= '0;
            vol_lat     <= '0;
            wave_pend   <= 1'b0;
            busy        <= 1'b0;
            step        <= '0;
            o_sample    <= '0;
        end else begin
            if (i_freq_load || tick) begin
                cnt <= i_freq;
            end else begin
                cnt <= cnt - 1'b1;
            end

            if (tick) begin
                o_play_addr <= o_play_addr + 1'b1;
                vol_lat     <= i_vol;
            end

            // Multiplier sequencing, a new tick aborts a running multiply
            wave_pend <= tick;
            if (tick) begin
                busy <= 1'b0;
            end else if (wave_pend) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end

            // Arithmetic shift right by VOL_W is the upper slice
            if (!i_enable) begin
                o_sample <= '0;
            end else if (busy && last_step) begin
                o_sample <= acc_next[SAMPLE_W+VOL_W-1:VOL_W];
            end
        end
    end

    //////////////////////////////////////////////////
    // Serial shift-add multiplier
    //////////////////////////////////////////////////

    // LSB first, the sign bit carries negative weight
    always_comb begin
        acc_next = acc;
        if (wave_sh[0]) begin
            if (last_step) begin
                acc_next = acc - addend;
            end else begin
                acc_next = acc + addend;
            end
        end
    end

    always_ff @(posedge emuclk) begin
        if (wave_pend) begin
            wave_sh <= i_wave;
            addend  <= {{SAMPLE_W{1'b0}}, vol_lat};
            acc     <= '0;
        end else if (busy) begin
            wave_sh <= wave_sh >> 1;
            addend  <= addend <<< 1;
            acc     <= acc_next;
        end
    end

endmodule

//--- src/scc_mixer.sv
`timescale 1ns/1ps

module scc_mixer
    import scc_pkg::*;
(
    input  logic                    emuclk,
    input  logic                    rst_n,
    input  wave_sample_t            i_samples [NUM_CH],
    output logic signed [MIX_W-1:0] o_sound
);

    logic signed [MIX_W-1:0] sum;

    // Sign extend each voice before adding
    always_comb begin
        sum = '0;
        for (int n = 0; n < NUM_CH; n++) begin
            sum = sum + MIX_W'(i_samples[n]);
        end
    end

    always_ff @(posedge emuclk or negedge rst_n) begin
        if (!rst_n) begin
            o_sound <= '0;
        end else begin
            o_sound <= sum;
        end
    end

endmodule

//--- src/scc_top.sv
`timescale 1ns/1ps

module scc_top
    import scc_pkg::*;
(
    input  logic                    emuclk,
    input  logic                    rst_n,
    input  logic                    i_cs_n,
    input  logic                    i_wr_n,
    input  logic                    i_rd_n,
    input  logic [7:0]              i_addr,
    input  logic [7:0]              i_data,
    output logic [7:0]              o_data,
    output logic signed [MIX_W-1:0] o_sound
);

    logic [NUM_CH-1:0]  ram_we;
    logic [WAVE_AW-1:0] ram_waddr;
    wave_sample_t       ram_wdata;
    wave_sample_t       ram_rdata [NUM_CH];
    freq_t              freq [NUM_CH];
    vol_t               vol [NUM_CH];
    logic [NUM_CH-1:0]  enable;
    logic [NUM_CH-1:0]  freq_load;
    logic [WAVE_AW-1:0] play_addr [NUM_CH];
    wave_sample_t       play_data [NUM_CH];
    wave_sample_t       samples [NUM_CH];

    //////////////////////////////////////////////////
    // CPU register block
    //////////////////////////////////////////////////

    scc_regs u_regs (
        .emuclk      (emuclk),
        .rst_n       (rst_n),
        .i_cs_n      (i_cs_n),
        .i_wr_n      (i_wr_n),
        .i_rd_n      (i_rd_n),
        .i_addr      (i_addr),
        .i_data      (i_data),
        .i_ram_rdata (ram_rdata),
        .o_data      (o_data),
        .o_ram_we    (ram_we),
        .o_ram_waddr (ram_waddr),
        .o_ram_wdata (ram_wdata),
        .o_freq      (freq),
        .o_vol       (vol),
        .o_enable    (enable),
        .o_freq_load (freq_load)
    );

    //////////////////////////////////////////////////
    // Voices with their wave RAMs
    //////////////////////////////////////////////////

    for (genvar n = 0; n < NUM_CH; n++) begin : g_voice
        scc_wave_ram u_ram (
            .emuclk      (emuclk),
            .rst_n       (rst_n),
            .i_we        (ram_we[n]),
            .i_waddr     (ram_waddr),
            .i_wdata     (ram_wdata),
            .i_play_addr (play_addr[n]),
            .o_play_data (play_data[n]),
            .o_cpu_data  (ram_rdata[n])
        );

        scc_voice u_voice (
            .emuclk      (emuclk),
            .rst_n       (rst_n),
            .i_freq      (freq[n]),
            .i_freq_load (freq_load[n]),
            .i_vol       (vol[n]),
            .i_enable    (enable[n]),
            .i_wave      (play_data[n]),
            .o_play_addr (play_addr[n]),
            .o_sample    (samples[n])
        );
    end

    scc_mixer u_mixer (
        .emuclk    (emuclk),
        .rst_n     (rst_n),
        .i_samples (samples),
        .o_sound   (o_sound)
    );

endmodule

//--- tests/scc_voice_asserts.sv
`timescale 1ns/1ps

module scc_voice_asserts
    import scc_pkg::*;
(
    input logic               emuclk,
    input logic               rst_n,
    input logic               i_tick,
    input logic               i_enable,
    input logic [WAVE_AW-1:0] i_play_addr,
    input wave_sample_t       i_sample
);

    // Index moves only on the cycle after a tick
    assert property (@(posedge emuclk) disable iff (!rst_n)
        (i_play_addr != $past(i_play_addr)) |-> $past(i_tick))
        else $error("Sample index changed without a tick");

    // Disabled voice is silent from the next cycle on
    assert property (@(posedge emuclk) disable iff (!rst_n)
        !i_enable |=> (i_sample == '0))
        else $error("Disabled voice drives a nonzero sample");

    assert property (@(posedge emuclk) $rose(rst_n) |-> (i_play_addr == '0))
        else $error("Sample index not zero after reset");

endmodule

bind scc_voice scc_voice_asserts u_voice_asserts (
    .emuclk      (emuclk),
    .rst_n       (rst_n),
    .i_tick      (tick),
    .i_enable    (i_enable),
    .i_play_addr (o_play_addr),
    .i_sample    (o_sample)
);

//--- tests/tb_scc.sv
`timescale 1ns/1ps

module tb_scc
    import scc_pkg::*;
();

    localparam int RAND_WRITES = 64;
    localparam int MAX_PERIOD  = 201;
    localparam int RAMP_EDGES  = 6;

    // Worst-case cycles of each test
    localparam int LEN_RESET   = 12;
    localparam int LEN_CLEAR   = 2 * NUM_CH * WAVE_DEPTH + 2;
    localparam int LEN_RANDOM  = 2 * (RAND_WRITES + NUM_CH * WAVE_DEPTH + 16);
    localparam int LEN_LEVEL   = 2 * NUM_CH * (WAVE_DEPTH + 3) + 410;
    localparam int LEN_MUTE    = 6;
    localparam int LEN_RAMP    = 2 * (WAVE_DEPTH + 5) + (RAMP_EDGES + 2) * MAX_PERIOD + 16;
    localparam int LEN_VOLUME  = 2 * (WAVE_DEPTH + 1) + 3 * MAX_PERIOD + 30;
    localparam int CYCLE_LIMIT = (LEN_RESET + LEN_CLEAR + LEN_RANDOM + LEN_LEVEL + LEN_MUTE
                                  + LEN_RAMP + LEN_VOLUME) * 3 / 2;

    logic                    emuclk;
    logic                    rst_n;
    logic                    cs_n;
    logic                    wr_n;
    logic                    rd_n;
    logic [7:0]              addr;
    logic [7:0]              wdata;
    logic [7:0]              rdata;
    logic signed [MIX_W-1:0] sound;

    logic [31:0]  lfsr_state = 32'd83955;
    int           cycles = 0;
    bit           fail_shown = 1'b0;
    bit           limit_hit = 1'b0;
    bit           run_done = 1'b0;
    logic [7:0]   ram_model [NUM_CH][WAVE_DEPTH];
    vol_t         vol_model [NUM_CH];
    wave_sample_t level [NUM_CH];

    scc_top uut (
        .emuclk  (emuclk),
        .rst_n   (rst_n),
        .i_cs_n  (cs_n),
        .i_wr_n  (wr_n),
        .i_rd_n  (rd_n),
        .i_addr  (addr),
        .i_data  (wdata),
        .o_data  (rdata),
        .o_sound (sound)
    );

    initial begin
        emuclk = 1'b0;
        forever #50 emuclk = ~emuclk;
    end

    always @(posedge emuclk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Cycle limit of %0d passed before the tests completed", CYCLE_LIMIT);
            $display("Finished with errors");
            limit_hit = 1'b1;
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // Random numbers and reference model
    //////////////////////////////////////////////////

    // Right-shifting Galois LFSR, polynomial x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Signed sample times volume, then arithmetic shift right by 4
    function automatic wave_sample_t voice_product(input wave_sample_t s, input vol_t v);
        int p;
        p = int'(s) * int'(v);
        return wave_sample_t'(p >>> 4);
    endfunction

    // Expected mix when every voice holds a constant wave
    function automatic logic signed [MIX_W-1:0] level_sum(input logic [NUM_CH-1:0] en);
        logic signed [MIX_W-1:0] s;
        s = '0;
        for (int n = 0; n < NUM_CH; n++) begin
            if (en[n]) begin
                s = s + MIX_W'(voice_product(level[n], vol_model[n]));
            end
        end
        return s;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Finished with errors");
        fail_shown = 1'b1;
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, read %0h, expected %0h", $time, msg, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sound(input logic signed [MIX_W-1:0] got,
                               input logic signed [MIX_W-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, o_sound %0d, expected %0d", $time, msg, got, exp);
            abort_run();
        end
    endtask

    task automatic check_interval(input int got, input int exp, input string msg);
        if (got != exp) begin
            $display("FAILED at %0t: %s, %0d cycles, expected %0d", $time, msg, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Bus access
    //////////////////////////////////////////////////

    task automatic write_bus(input logic [7:0] a, input logic [7:0] d);
        @(posedge emuclk);
        cs_n  <= 1'b0;
        wr_n  <= 1'b0;
        addr  <= a;
        wdata <= d;
        @(posedge emuclk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    task automatic read_bus(input logic [7:0] a, output logic [7:0] d);
        @(posedge emuclk);
        cs_n <= 1'b0;
        rd_n <= 1'b0;
        addr <= a;
        @(negedge emuclk);
        d = rdata;
        @(posedge emuclk);
        cs_n <= 1'b1;
        rd_n <= 1'b1;
    endtask

    task automatic write_wave(input int v, input int i, input logic [7:0] d);
        scc_addr_u a;
        a.wave.voice = 3'(v);
        a.wave.index = 5'(i);
        write_bus(a, d);
        ram_model[v][i] = d;
    endtask

    task automatic expect_wave(input int v, input int i);
        scc_addr_u  a;
        logic [7:0] d;
        a.wave.voice = 3'(v);
        a.wave.index = 5'(i);
        read_bus(a, d);
        check_data(d, ram_model[v][i], $sformatf("wave voice %0d index %0d", v, i));
    endtask

    task automatic write_freq(input int v, input int f);
        write_bus(FREQ_BASE + 8'(2 * v), 8'(f));
        write_bus(FREQ_BASE + 8'(2 * v + 1), 8'(f >> 8));
    endtask

    task automatic write_vol(input int v, input vol_t vol);
        write_bus(VOL_BASE + 8'(v), 8'(vol));
        vol_model[v] = vol;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge emuclk);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [7:0]              d;
        logic [NUM_CH-1:0]       en;
        int                      v_sel;
        int                      idx;
        int                      freq;
        int                      m;
        int                      last;
        int                      edges;
        bit                      seen_new;
        logic signed [MIX_W-1:0] prev;
        logic signed [MIX_W-1:0] old_sound;
        logic signed [MIX_W-1:0] new_sound;

        rst_n = 1'b0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        rd_n  = 1'b1;
        addr  = '0;
        wdata = '0;
        for (int v = 0; v < NUM_CH; v++) begin
            vol_model[v] = '0;
            level[v]     = '0;
            for (int i = 0; i < WAVE_DEPTH; i++) begin
                ram_model[v][i] = '0;
            end
        end
        repeat (10) @(posedge emuclk);
        rst_n <= 1'b1;
        @(posedge emuclk);

        // Everything clear after reset
        @(negedge emuclk);
        check_sound(sound, '0, "o_sound after reset");
        for (int v = 0; v < NUM_CH; v++) begin
            for (int i = 0; i < WAVE_DEPTH; i++) begin
                expect_wave(v, i);
            end
        end

        // Random wave writes, then full read-back
        for (int k = 0; k < RAND_WRITES; k++) begin
            v_sel = int'(take_bits(2) % 3);
            idx   = int'(take_bits(5));
            write_wave(v_sel, idx, 8'(take_bits(8)));
        end
        for (int v = 0; v < NUM_CH; v++) begin
            for (int i = 0; i < WAVE_DEPTH; i++) begin
                expect_wave(v, i);
            end
        end
        for (int r = 0; r < 16; r++) begin
            read_bus(FREQ_BASE + 8'(r), d);
            check_data(d, 8'h00, "register address read");
        end

        // Constant waves with random volumes on all voices
        for (int v = 0; v < NUM_CH; v++) begin
            level[v] = wave_sample_t'(take_bits(8));
            for (int i = 0; i < WAVE_DEPTH; i++) begin
                write_wave(v, i, level[v]);
            end
            write_vol(v, vol_t'(take_bits(4)));
            freq = 16 + int'(take_bits(8) % 185);
            write_freq(v, freq);
        end
        write_bus(MUTE_ADDR, 8'h07);
        wait_cycles(400);
        @(negedge emuclk);
        check_sound(sound, level_sum(3'b111), "mix of three constant waves");

        // Mute one voice
        m  = int'(take_bits(2) % 3);
        en = 3'b111 & ~(3'b001 << m);
        write_bus(MUTE_ADDR, 8'(en));
        wait_cycles(2);
        @(negedge emuclk);
        check_sound(sound, level_sum(en), "mix after muting one voice");

        // Ramp on voice 0 alone, o_sound steps once per period
        write_bus(MUTE_ADDR, 8'h00);
        for (int i = 0; i < WAVE_DEPTH; i++) begin
            write_wave(0, i, 8'(8 * i - 128));
        end
        write_vol(0, 4'hF);
        freq = 16 + int'(take_bits(8) % 185);
        write_freq(0, freq);
        write_bus(MUTE_ADDR, 8'h01);
        wait_cycles(freq + 16);
        @(negedge emuclk);
        prev  = sound;
        last  = -1;
        edges = 0;
        while (edges < RAMP_EDGES) begin
            @(negedge emuclk);
            if (sound !== prev) begin
                if (last >= 0) begin
                    check_interval(cycles - last, freq + 1, "spacing of o_sound changes");
                end
                last = cycles;
                prev = sound;
                edges++;
            end
        end

        // Volume rewrite on a constant wave
        level[0] = wave_sample_t'(8'(take_bits(7)) + 8'd64);
        for (int i = 0; i < WAVE_DEPTH; i++) begin
            write_wave(0, i, level[0]);
        end
        wait_cycles(2 * (freq + 1) + 12);
        @(negedge emuclk);
        old_sound = level_sum(3'b001);
        check_sound(sound, old_sound, "voice 0 before the volume change");
        write_vol(0, vol_t'(14 - int'(take_bits(3))));
        new_sound = level_sum(3'b001);
        seen_new  = 1'b0;
        // One period plus 11 cycles from the register update
        for (int k = 0; k < freq + 13; k++) begin
            @(negedge emuclk);
            if (seen_new || sound !== old_sound) begin
                check_sound(sound, new_sound, "o_sound after the volume change");
                seen_new = 1'b1;
            end
        end
        check_sound(sound, new_sound, "o_sound settled on the new volume");

        if (!fail_shown) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        run_done = 1'b1;
        $finish;
    end

    final begin
        if (!run_done && !fail_shown && !limit_hit) begin
            $display("Finished with errors");
        end
    end

endmodule

//--- compile.f
src/scc_pkg.sv
src/scc_regs.sv
src/scc_wave_ram.sv
src/scc_voice.sv
src/scc_mixer.sv
src/scc_top.sv
tests/scc_voice_asserts.sv
tests/tb_scc.sv

//--- run.sh
#!/bin/sh
# Build and run the SCC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_scc -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_scc)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
